// File: build.f
hdl/mcu_peri_pkg.sv
hdl/cmd_bridge.sv
hdl/pmod_gpio.sv
hdl/mailbox_regs.sv
hdl/rsp_merge.sv
hdl/mcu_peri_top.sv
sim/mcu_peri_chk.sv
sim/mcu_peri_tb.sv

// File: hdl/cmd_bridge.sv
// -------------------------------------
// Host command bridge
// Queues host commands, returns one credit per pop and runs
// one access at a time on the peripheral bus. Unmapped
// regions skip the bus and raise err_push_o instead.
// -------------------------------------

module cmd_bridge #(
    parameter int CMD_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_valid_i,
    input  mcu_peri_pkg::cmd_t       cmd_i,
    output logic                     cmd_credit_o,
    input  logic                     rsp_room_i,
    output mcu_peri_pkg::bus_req_t   bus_req_o,
    output logic                     gpio_stb_o,
    output logic                     mbox_stb_o,
    input  logic                     gpio_ack_i,
    input  logic                     mbox_ack_i,
    output logic                     err_push_o
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    mcu_peri_pkg::cmd_t            fifo_mem [CMD_DEPTH];
    mcu_peri_pkg::cmd_t            head_cmd;
    mcu_peri_pkg::cmd_t            cur_cmd;
    logic [PTR_W-1:0]              wr_ptr;
    logic [PTR_W-1:0]              rd_ptr;
    logic [CNT_W-1:0]              fifo_cnt;
    logic                          push;
    logic                          pop;
    logic                          sel_gpio;
    logic                          sel_mbox;
    mcu_peri_pkg::bridge_state_e   state;
    mcu_peri_pkg::bridge_state_e   state_next;

    // -------------------------------------
    // Command FIFO
    // -------------------------------------
    // Host never sends without a credit, full check is only a guard
    assign push     = cmd_valid_i && (fifo_cnt != CNT_W'(CMD_DEPTH));
    assign head_cmd = fifo_mem[rd_ptr];

    // Pop only when the response queue can take the result
    assign pop          = (state == mcu_peri_pkg::ST_IDLE) && (fifo_cnt != '0) && rsp_room_i;
    assign cmd_credit_o = pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                fifo_cnt <= fifo_cnt + 1'b1;
            end else if (pop && !push) begin
                fifo_cnt <= fifo_cnt - 1'b1;
            end
        end
    end

    // Storage and current command, decoded once at pop
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= cmd_i;
        end
        if (pop) begin
            cur_cmd  <= head_cmd;
            sel_gpio <= (head_cmd.addr[15:12] == mcu_peri_pkg::REGION_GPIO);
            sel_mbox <= (head_cmd.addr[15:12] == mcu_peri_pkg::REGION_MBOX);
        end
    end

    // -------------------------------------
    // Bus access FSM
    // -------------------------------------
    assign bus_req_o.we   = (cur_cmd.op == mcu_peri_pkg::OP_WRITE);
    assign bus_req_o.addr = cur_cmd.addr;
    assign bus_req_o.data = cur_cmd.data;
    assign bus_req_o.sel  = cur_cmd.sel;

    // Strobe held through ST_ACCESS until the peripheral acks
    assign gpio_stb_o = (state == mcu_peri_pkg::ST_ACCESS) && sel_gpio;
    assign mbox_stb_o = (state == mcu_peri_pkg::ST_ACCESS) && sel_mbox;
    assign err_push_o = (state == mcu_peri_pkg::ST_ACCESS) && !sel_gpio && !sel_mbox;

    always_comb begin
        state_next = state;
        case (state)
            mcu_peri_pkg::ST_IDLE: begin
                if (pop) begin
                    state_next = mcu_peri_pkg::ST_ACCESS;
                end
            end
            mcu_peri_pkg::ST_ACCESS: begin
                if (err_push_o || (gpio_stb_o && gpio_ack_i) || (mbox_stb_o && mbox_ack_i)) begin
                    state_next = mcu_peri_pkg::ST_RESPOND;
                end
            end
            mcu_peri_pkg::ST_RESPOND: begin
                state_next = mcu_peri_pkg::ST_IDLE;
            end
            default: begin
                state_next = mcu_peri_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mcu_peri_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: hdl/mailbox_regs.sv
// -------------------------------------
// Mailbox word registers
// MBOX_WORDS words indexed by the low address bits. Byte
// strobes select the lanes written. Read data and ack come
// one cycle after the strobe.
// -------------------------------------

module mailbox_regs #(
    parameter int MBOX_WORDS = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                stb_i,
    input  mcu_peri_pkg::bus_req_t              req_i,
    output logic                                ack_o,
    output logic [mcu_peri_pkg::DATA_W-1:0]     rdata_o
);

    localparam int IDX_W = $clog2(MBOX_WORDS);

    logic [mcu_peri_pkg::DATA_W-1:0] mem [MBOX_WORDS];
    logic [IDX_W-1:0]                word_idx;
    logic                            access;

    assign word_idx = req_i.addr[IDX_W-1:0];

    // First strobe cycle only, second cycle is the ack cycle
    assign access = stb_i && !ack_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_o <= 1'b0;
            for (int w = 0; w < MBOX_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else begin
            ack_o <= access;
            if (access && req_i.we) begin
                for (int b = 0; b < mcu_peri_pkg::SEL_W; b++) begin
                    if (req_i.sel[b]) begin
                        mem[word_idx][8*b +: 8] <= req_i.data[8*b +: 8];
                    end
                end
            end
        end
    end

    // Word as stored before this access, so a write returns the old value
    always_ff @(posedge clk) begin
        if (access) begin
            rdata_o <= mem[word_idx];
        end
    end

endmodule

// File: hdl/mcu_peri_pkg.sv
// -------------------------------------
// Shared types for the peripheral subsystem
// Command and response records, bus request, FSM states
// and the address map. Modules refer to items by scoped name.
// -------------------------------------

package mcu_peri_pkg;

    // -------------------------------------
    // Widths
    // -------------------------------------
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    // Region codes in address bits 15:12
    localparam logic [3:0] REGION_GPIO = 4'h1;
    localparam logic [3:0] REGION_MBOX = 4'h2;

    // -------------------------------------
    // Enums
    // -------------------------------------
    typedef enum logic [0:0] {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } opcode_e;

    typedef enum logic [0:0] {
        RSP_OK     = 1'b0,
        RSP_DECERR = 1'b1
    } status_e;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_ACCESS  = 2'd1,
        ST_RESPOND = 2'd2
    } bridge_state_e;

    // -------------------------------------
    // Records
    // -------------------------------------
    // Host command, 53 bits
    typedef struct packed {
        opcode_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
        logic [SEL_W-1:0]    sel;
    } cmd_t;

    // Host response, 33 bits
    typedef struct packed {
        status_e             status;
        logic [DATA_W-1:0]   data;
    } rsp_t;

    // Single-cycle peripheral bus request, 53 bits
    typedef struct packed {
        logic                we;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
        logic [SEL_W-1:0]    sel;
    } bus_req_t;

endpackage

// File: hdl/mcu_peri_top.sv
// -------------------------------------
// Peripheral subsystem top level
// Host command channel in, credited response stream out,
// PMOD pins driven from the GPIO port.
// -------------------------------------

module mcu_peri_top #(
    parameter int CMD_DEPTH  = 4,
    parameter int RSP_DEPTH  = 4,
    parameter int MBOX_WORDS = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_valid_i,
    input  mcu_peri_pkg::cmd_t      cmd_i,
    output logic                    cmd_credit_o,
    input  logic                    rsp_credit_i,
    output logic                    rsp_valid_o,
    output mcu_peri_pkg::rsp_t      rsp_o,
    output logic [7:0]              pmod_o
);

    // -------------------------------------
    // Peripheral bus
    // -------------------------------------
    mcu_peri_pkg::bus_req_t            bus_req;
    logic                              gpio_stb;
    logic                              mbox_stb;
    logic                              gpio_ack;
    logic                              mbox_ack;
    logic [mcu_peri_pkg::DATA_W-1:0]   gpio_rdata;
    logic [mcu_peri_pkg::DATA_W-1:0]   mbox_rdata;

    // Bridge to merger
    logic                              err_push;
    logic                              rsp_room;

    cmd_bridge #(
        .CMD_DEPTH    (CMD_DEPTH)
    ) u_cmd_bridge (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .cmd_credit_o (cmd_credit_o),
        .rsp_room_i   (rsp_room),
        .bus_req_o    (bus_req),
        .gpio_stb_o   (gpio_stb),
        .mbox_stb_o   (mbox_stb),
        .gpio_ack_i   (gpio_ack),
        .mbox_ack_i   (mbox_ack),
        .err_push_o   (err_push)
    );

    pmod_gpio u_pmod_gpio (
        .clk          (clk),
        .reset        (reset),
        .stb_i        (gpio_stb),
        .req_i        (bus_req),
        .ack_o        (gpio_ack),
        .rdata_o      (gpio_rdata),
        .pmod_o       (pmod_o)
    );

    mailbox_regs #(
        .MBOX_WORDS   (MBOX_WORDS)
    ) u_mailbox_regs (
        .clk          (clk),
        .reset        (reset),
        .stb_i        (mbox_stb),
        .req_i        (bus_req),
        .ack_o        (mbox_ack),
        .rdata_o      (mbox_rdata)
    );

    rsp_merge #(
        .RSP_DEPTH    (RSP_DEPTH)
    ) u_rsp_merge (
        .clk          (clk),
        .reset        (reset),
        .gpio_ack_i   (gpio_ack),
        .mbox_ack_i   (mbox_ack),
        .gpio_rdata_i (gpio_rdata),
        .mbox_rdata_i (mbox_rdata),
        .err_push_i   (err_push),
        .rsp_room_o   (rsp_room),
        .rsp_credit_i (rsp_credit_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

endmodule

// File: hdl/pmod_gpio.sv
// -------------------------------------
// 8-bit PMOD output port
// One pin per word address, set from data bit 0 when byte
// lane 0 is enabled. Acks in the strobe cycle.
// -------------------------------------

module pmod_gpio (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                stb_i,
    input  mcu_peri_pkg::bus_req_t              req_i,
    output logic                                ack_o,
    output logic [mcu_peri_pkg::DATA_W-1:0]     rdata_o,
    output logic [7:0]                          pmod_o
);

    logic [7:0] pin_reg;
    logic       pin_we;

    // Pin write enable
    assign pin_we = stb_i && req_i.we && req_i.sel[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            pin_reg <= '0;
        end else if (pin_we) begin
            // Address bits 2:0 pick the pin, others hold
            pin_reg[req_i.addr[2:0]] <= req_i.data[0];
        end
    end

    // Zero-latency slave
    assign ack_o = stb_i;

    // Whole register back on reads, upper bits zero
    assign rdata_o = {{(mcu_peri_pkg::DATA_W - 8){1'b0}}, pin_reg};

    assign pmod_o = pin_reg;

endmodule

// File: hdl/rsp_merge.sv
// -------------------------------------
// Response merger
// Turns GPIO acks, mailbox acks and decode errors into rsp_t
// entries, queues them in order and releases one per cycle
// while the host has granted credits.
// -------------------------------------

module rsp_merge #(
    parameter int RSP_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                gpio_ack_i,
    input  logic                                mbox_ack_i,
    input  logic [mcu_peri_pkg::DATA_W-1:0]     gpio_rdata_i,
    input  logic [mcu_peri_pkg::DATA_W-1:0]     mbox_rdata_i,
    input  logic                                err_push_i,
    output logic                                rsp_room_o,
    input  logic                                rsp_credit_i,
    output logic                                rsp_valid_o,
    output mcu_peri_pkg::rsp_t                  rsp_o
);

    localparam int PTR_W    = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
    localparam int CNT_W    = $clog2(RSP_DEPTH + 1);
    localparam int CREDIT_W = 16;

    mcu_peri_pkg::rsp_t    fifo_mem [RSP_DEPTH];
    mcu_peri_pkg::rsp_t    push_rsp;
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      fifo_cnt;
    logic [CREDIT_W-1:0]   credit_cnt;
    logic                  push;
    logic                  pop;

    // -------------------------------------
    // Source select
    // -------------------------------------
    assign push = (gpio_ack_i || mbox_ack_i || err_push_i) && rsp_room_o;

    always_comb begin
        push_rsp.status = err_push_i ? mcu_peri_pkg::RSP_DECERR : mcu_peri_pkg::RSP_OK;
        if (gpio_ack_i) begin
            push_rsp.data = gpio_rdata_i;
        end else if (mbox_ack_i) begin
            push_rsp.data = mbox_rdata_i;
        end else begin
            push_rsp.data = '0;
        end
    end

    // -------------------------------------
    // Response queue and credits
    // -------------------------------------
    assign rsp_room_o  = (fifo_cnt != CNT_W'(RSP_DEPTH));
    assign pop         = (fifo_cnt != '0) && (credit_cnt != '0);
    assign rsp_valid_o = pop;
    assign rsp_o       = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_cnt   <= '0;
            credit_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                fifo_cnt <= fifo_cnt + 1'b1;
            end else if (pop && !push) begin
                fifo_cnt <= fifo_cnt - 1'b1;
            end
            // Grant and spend in one cycle cancel out
            if (rsp_credit_i && !pop && (credit_cnt != '1)) begin
                credit_cnt <= credit_cnt + 1'b1;
            end else if (pop && !rsp_credit_i) begin
                credit_cnt <= credit_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= push_rsp;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench and judge the log
verilator --binary --timing --assert -Wno-fatal --top-module mcu_peri_tb -f build.f \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vmcu_peri_tb > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "RESULT: passed" || { echo "RESULT: failed"; exit 1; }

// File: sim/mcu_peri_chk.sv
// ----------------------------------------
// Protocol assertions for the peripheral subsystem
// Bound into mcu_peri_top, watches credits and bus strobes
// ----------------------------------------

module mcu_peri_chk (
    input logic clk,
    input logic reset,
    input logic cmd_valid_i,
    input logic cmd_credit_i,
    input logic rsp_credit_i,
    input logic rsp_valid_i,
    input logic gpio_stb_i,
    input logic mbox_stb_i
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] rsp_credits;
    logic [7:0]  cmd_backlog;

    // Reference counts of granted credits and queued commands
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_credits <= '0;
            cmd_backlog <= '0;
        end else begin
            rsp_credits <= rsp_credits + 16'(rsp_credit_i) - 16'(rsp_valid_i);
            cmd_backlog <= cmd_backlog + 8'(cmd_valid_i) - 8'(cmd_credit_i);
        end
    end

    a_rsp_needs_credit: assert property (
        @(posedge clk) disable iff (reset) rsp_valid_i |-> (rsp_credits != '0)
    ) else $error("rsp_valid_o high with no response credit");

    a_one_strobe: assert property (
        @(posedge clk) disable iff (reset) !(gpio_stb_i && mbox_stb_i)
    ) else $error("gpio_stb and mbox_stb high together");

    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset) cmd_credit_i |-> (cmd_backlog != '0)
    ) else $error("cmd_credit_o without a queued command");

endmodule

bind mcu_peri_top mcu_peri_chk u_mcu_peri_chk (
    .clk          (clk),
    .reset        (reset),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_credit_i (cmd_credit_o),
    .rsp_credit_i (rsp_credit_i),
    .rsp_valid_i  (rsp_valid_o),
    .gpio_stb_i   (gpio_stb),
    .mbox_stb_i   (mbox_stb)
);

// File: sim/mcu_peri_golden.hex
// op(0 wr 1 rd) addr data sel | status(1 decerr) rdata pmod-after
// write rdata is the register value before the write
0 1000 00000001 1 0 00000000 01
0 1003 00000001 1 0 00000001 09
0 1007 000000FF E 0 00000009 09
1 1000 00000000 F 0 00000009 09
0 2001 A1B2C3D4 F 0 00000000 09
0 2001 55667788 5 0 A1B2C3D4 09
1 2001 00000000 F 0 A166C388 09
0 3000 DEADBEEF F 1 00000000 09
1 0004 00000000 F 1 00000000 09
0 1007 00000001 1 0 00000009 89
0 2002 0000FFEE 3 0 00000000 89
1 1000 00000000 F 0 00000089 89
1 2002 00000000 F 0 0000FFEE 89
0 1003 00000000 1 0 00000089 81
1 2001 00000000 F 0 A166C388 81
0 2000 12345678 8 0 00000000 81
0 F001 00000001 1 1 00000000 81
1 1005 00000000 F 0 00000081 81
1 2000 00000000 F 0 12000000 81
1 2003 00000000 F 0 00000000 81

// File: sim/mcu_peri_tb.sv
// ----------------------------------------
// Testbench for the peripheral subsystem
// Sends the golden file commands under command credits, holds
// response credits back for a stretch, then grants them at random
// and checks responses and PMOD pins against the file
// ----------------------------------------

module mcu_peri_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // Mirrors the top level default
    localparam int CMD_DEPTH   = 4;
    localparam int NUM_CMDS    = 20;
    localparam int FIELDS      = 7;
    localparam int HOLD_CYCLES = 40;
    localparam int TIMEOUT     = 200;
    // Longer than any gap between pops of a bridge that is not held back
    localparam int STALL_MIN   = 8;
    localparam logic [31:0] SEED = 32'h7748_b17d;

    logic                clk = 1'b0;
    logic                reset;
    logic                cmd_valid_i;
    mcu_peri_pkg::cmd_t  cmd_i;
    logic                cmd_credit_o;
    logic                rsp_credit_i;
    logic                rsp_valid_o;
    mcu_peri_pkg::rsp_t  rsp_o;
    logic [7:0]          pmod_o;

    // Golden file columns are op addr data sel status rdata pmod
    logic [31:0] golden_mem [NUM_CMDS*FIELDS];
    logic [7:0]  pin_exp;
    int          error_cnt   = 0;
    int          pop_cnt     = 0;
    int          rsp_seen    = 0;
    int          grant_seen  = 0;
    logic        hold_active = 1'b0;
    logic        stall_seen  = 1'b0;
    logic        rx_done     = 1'b0;

    mcu_peri_top dut (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .cmd_credit_o (cmd_credit_o),
        .rsp_credit_i (rsp_credit_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o),
        .pmod_o       (pmod_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] golden_field(input int idx, input int col);
        return golden_mem[idx*FIELDS + col];
    endfunction

    function automatic logic [7:0] golden_pmod(input int idx);
        logic [31:0] word;
        word = golden_field(idx, 6);
        return word[7:0];
    endfunction

    function automatic mcu_peri_pkg::cmd_t cmd_from_golden(input int idx);
        mcu_peri_pkg::cmd_t c;
        logic [31:0]        word;
        word   = golden_field(idx, 0);
        c.op   = mcu_peri_pkg::opcode_e'(word[0]);
        word   = golden_field(idx, 1);
        c.addr = word[mcu_peri_pkg::ADDR_W-1:0];
        c.data = golden_field(idx, 2);
        word   = golden_field(idx, 3);
        c.sel  = word[mcu_peri_pkg::SEL_W-1:0];
        return c;
    endfunction

    // ----------------------------------------
    // Pin and credit monitor
    // ----------------------------------------
    // At each pop the previous command has finished on the bus
    always @(negedge clk) begin
        if (!reset) begin
            if (cmd_credit_o) begin
                pin_exp = (pop_cnt == 0) ? 8'h00 : golden_pmod(pop_cnt - 1);
                if (pop_cnt < NUM_CMDS && pmod_o !== pin_exp) begin
                    $display("FAIL cmd %0d pmod_o: got %h expected %h",
                             pop_cnt - 1, pmod_o, pin_exp);
                    error_cnt++;
                end
                pop_cnt++;
            end
            if (rsp_valid_o && (hold_active || rsp_seen >= grant_seen)) begin
                $display("response %0d sent without a granted credit", rsp_seen);
                error_cnt++;
            end
            if (rsp_valid_o) begin
                rsp_seen++;
            end
            if (rsp_credit_i) begin
                grant_seen++;
            end
        end
    end

    // ----------------------------------------
    // Host side processes
    // ----------------------------------------
    task automatic send_commands();
        int credits;
        int idx;
        int idle;
        credits = CMD_DEPTH;
        idx     = 0;
        idle    = 0;
        while (idx < NUM_CMDS && idle < TIMEOUT) begin
            @(negedge clk);
            if (cmd_credit_o) begin
                credits++;
            end
            @(posedge clk);
            if (credits > 0) begin
                cmd_valid_i <= 1'b1;
                cmd_i       <= cmd_from_golden(idx);
                credits--;
                idx++;
                idle = 0;
            end else begin
                cmd_valid_i <= 1'b0;
                idle++;
                if (hold_active && idle >= STALL_MIN) begin
                    stall_seen = 1'b1;
                end
            end
        end
        if (idx < NUM_CMDS) begin
            $display("timeout: no command credit came back for %0d cycles", TIMEOUT);
            error_cnt++;
        end
        @(posedge clk);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic grant_credits();
        int cycles;
        cycles      = 0;
        hold_active = 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        hold_active = 1'b0;
        while (!rx_done && cycles < 20*TIMEOUT) begin
            @(posedge clk);
            rsp_credit_i <= (($urandom() % 3) == 0);
            cycles++;
        end
        @(posedge clk);
        rsp_credit_i <= 1'b0;
    endtask

    task automatic receive_responses();
        mcu_peri_pkg::rsp_t rsp;
        logic [31:0]        exp_status;
        logic [31:0]        exp_data;
        int                 waited;
        logic               bad;
        logic               timed_out;
        timed_out = 1'b0;
        for (int k = 0; k < NUM_CMDS && !timed_out; k++) begin
            waited = 0;
            @(negedge clk);
            while (!rsp_valid_o && waited < TIMEOUT) begin
                waited++;
                @(negedge clk);
            end
            if (!rsp_valid_o) begin
                $display("timeout: no response for command %0d in %0d cycles", k, TIMEOUT);
                error_cnt++;
                timed_out = 1'b1;
            end else begin
                rsp        = rsp_o;
                exp_status = golden_field(k, 4);
                exp_data   = golden_field(k, 5);
                bad        = 1'b0;
                if (rsp.status !== exp_status[0]) begin
                    $display("FAIL cmd %0d rsp_o.status: got %h expected %h",
                             k, rsp.status, exp_status[0]);
                    bad = 1'b1;
                end
                if (rsp.data !== exp_data) begin
                    $display("FAIL cmd %0d rsp_o.data: got %h expected %h",
                             k, rsp.data, exp_data);
                    bad = 1'b1;
                end
                if (bad) begin
                    error_cnt++;
                end else begin
                    $display("cmd %0d addr %h: ok", k, golden_field(k, 1));
                end
            end
        end
        rx_done = 1'b1;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(SEED));
        reset        = 1'b1;
        cmd_valid_i  = 1'b0;
        cmd_i        = '0;
        rsp_credit_i = 1'b0;
        $readmemh("sim/mcu_peri_golden.hex", golden_mem);
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (pmod_o !== 8'h00) begin
            $display("FAIL reset pmod_o: got %h expected 00", pmod_o);
            error_cnt++;
        end else begin
            $display("reset state: ok");
        end
        fork
            send_commands();
            grant_credits();
            receive_responses();
        join
        // Quiet period catches stray responses
        repeat (10) @(negedge clk);
        if (pmod_o !== golden_pmod(NUM_CMDS - 1)) begin
            $display("FAIL final pmod_o: got %h expected %h",
                     pmod_o, golden_pmod(NUM_CMDS - 1));
            error_cnt++;
        end
        if (rsp_seen != NUM_CMDS || pop_cnt != NUM_CMDS) begin
            $display("expected %0d pops and responses, saw %0d pops and %0d responses",
                     NUM_CMDS, pop_cnt, rsp_seen);
            error_cnt++;
        end
        if (!stall_seen) begin
            $display("sender kept getting command credits during the credit hold");
            error_cnt++;
        end else begin
            $display("credit hold: sender stalled, ok");
        end
        $display("done: %0d commands, %0d responses, %0d errors",
                 NUM_CMDS, rsp_seen, error_cnt);
        if (error_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
